/* design/ws2812_pkg.sv */
/*
 * WS2812 driver shared definitions.
 * Widths, bit timing, the memory word layout and the stage-to-stage types.
 */

package ws2812_pkg;

    // **************************************************
    // sizes and bit timing (20 MHz clock).
    // **************************************************
    localparam int ADDR_W        = 6;
    localparam int RAM_DEPTH     = 1 << ADDR_W;
    localparam int GRB_W         = 24;
    localparam int LINK_LSB      = 24;
    localparam int LAST_BIT      = 31;

    localparam int PIXEL_CREDITS = 2;
    localparam int CREDIT_W      = 2;

    // one bit period is 1.25 us.
    localparam int BIT_CYCLES    = 25;
    localparam int T0H_CYCLES    = 8;
    localparam int T1H_CYCLES    = 16;

    // **************************************************
    // vector types.
    // **************************************************
    typedef logic [ADDR_W-1:0] ram_addr_t;
    typedef logic [GRB_W-1:0]  grb_t;
    // last flag, reserved, next address, colour.
    typedef logic [31:0]       ram_word_t;
    typedef logic [3:0]        byte_en_t;
    typedef logic [15:0]       reset_len_t;

    typedef struct packed {
        grb_t grb;
        logic last;
    } pixel_beat_t;

    typedef enum logic [1:0] {
        SYM_ZERO,
        SYM_ONE,
        SYM_RESET
    } symbol_kind_e;

    typedef struct packed {
        symbol_kind_e kind;
    } symbol_t;

    typedef enum logic [1:0] {
        RD_IDLE,
        RD_FETCH,
        RD_WAIT_CREDIT
    } reader_state_e;

    typedef enum logic [1:0] {
        ENC_IDLE,
        ENC_HIGH,
        ENC_LOW,
        ENC_RESET
    } encoder_state_e;

endpackage

/* design/pixel_ram.sv */
/*
 * Pixel memory, 64 words of 32 bits.
 * Byte-lane writes from the host, one registered read port for the reader.
 */

`timescale 1ns/1ns

module pixel_ram
    import ws2812_pkg::*;
(
    input  logic       clk_in,
    input  logic       rst_n_in,
    input  logic       wr_en,
    input  ram_addr_t  wr_addr,
    input  logic [7:0] wr_data,
    input  byte_en_t   wr_byte_en,
    input  logic       rd_en,
    input  ram_addr_t  rd_addr,
    output ram_word_t  rd_word
);

    ram_word_t mem [RAM_DEPTH];

    // the data byte goes to every enabled lane.
    always_ff @(posedge clk_in) begin
        for (int i = 0; i < 4; i++) begin
            if (wr_en && wr_byte_en[i]) begin
                mem[wr_addr][i*8 +: 8] <= wr_data;
            end
        end
    end

    // read word holds until the next rd_en.
    always_ff @(posedge clk_in or negedge rst_n_in) begin
        if (!rst_n_in) begin
            rd_word <= '0;
        end else if (rd_en) begin
            rd_word <= mem[rd_addr];
        end
    end

endmodule

/* design/frame_reader.sv */
/*
 * Frame reader.
 * Follows the linked pixel chain from entry 0 and hands pixels
 * to the serializer under credit control.
 */

`timescale 1ns/1ns

module frame_reader
    import ws2812_pkg::*;
(
    input  logic        clk_in,
    input  logic        rst_n_in,
    input  logic        start,
    output logic        rd_en,
    output ram_addr_t   rd_addr,
    input  ram_word_t   rd_word,
    output logic        pix_valid,
    output pixel_beat_t pix_beat,
    input  logic        pix_credit,
    output logic        busy
);

    reader_state_e       state;
    logic [CREDIT_W-1:0] credits;
    // rd_word carries fresh data this cycle.
    logic                data_ok;
    logic                send;

    // **************************************************
    // pixel hand-off.
    // **************************************************
    assign send = ((state == RD_FETCH && data_ok) || state == RD_WAIT_CREDIT)
                  && (credits != '0);

    assign pix_valid     = send;
    assign pix_beat.grb  = rd_word[GRB_W-1:0];
    assign pix_beat.last = rd_word[LAST_BIT];

    // stays busy until the serializer has given back every slot.
    assign busy = (state != RD_IDLE) || (credits != CREDIT_W'(PIXEL_CREDITS));

    // **************************************************
    // chain walk.
    // **************************************************
    always_ff @(posedge clk_in or negedge rst_n_in) begin
        if (!rst_n_in) begin
            state   <= RD_IDLE;
            rd_en   <= 1'b0;
            rd_addr <= '0;
            data_ok <= 1'b0;
            credits <= CREDIT_W'(PIXEL_CREDITS);
        end else begin
            rd_en   <= 1'b0;
            data_ok <= rd_en;
            credits <= credits - CREDIT_W'(send) + CREDIT_W'(pix_credit);

            case (state)
                RD_IDLE: begin
                    if (start) begin
                        state   <= RD_FETCH;
                        rd_en   <= 1'b1;
                        rd_addr <= '0;
                    end
                end
                RD_FETCH: begin
                    if (data_ok && !send) begin
                        state <= RD_WAIT_CREDIT;
                    end
                end
                RD_WAIT_CREDIT: begin
                    // waits here with the word held in the memory register.
                end
                default: begin
                    state <= RD_IDLE;
                end
            endcase

            // a sent pixel either ends the frame or fetches its successor.
            if (send) begin
                if (rd_word[LAST_BIT]) begin
                    state <= RD_IDLE;
                end else begin
                    state   <= RD_FETCH;
                    rd_en   <= 1'b1;
                    rd_addr <= rd_word[LINK_LSB +: ADDR_W];
                end
            end
        end
    end

    // the serializer never hands back more slots than it was given.
    assert property (@(posedge clk_in) disable iff (!rst_n_in)
        credits <= CREDIT_W'(PIXEL_CREDITS));

endmodule

/* design/bit_serializer.sv */
/*
 * Bit serializer.
 * Two pixel slots, sent MSB first as bit symbols, with a reset
 * symbol after the last pixel of a frame.
 */

`timescale 1ns/1ns

module bit_serializer
    import ws2812_pkg::*;
(
    input  logic        clk_in,
    input  logic        rst_n_in,
    input  logic        pix_valid,
    input  pixel_beat_t pix_beat,
    output logic        pix_credit,
    output logic        sym_valid,
    output symbol_t     sym,
    input  logic        sym_credit
);

    pixel_beat_t              slot_q [PIXEL_CREDITS];
    logic [PIXEL_CREDITS-1:0] slot_full;
    logic                     wr_ptr;
    logic                     rd_ptr;
    logic [4:0]               bit_idx;
    logic                     sym_cred;
    logic                     reset_pend;
    logic                     send_bit;
    logic                     send_rst;
    pixel_beat_t              cur;

    assign cur      = slot_q[rd_ptr];
    // a pending reset goes out before the next frame's bits.
    assign send_rst = reset_pend & sym_cred;
    assign send_bit = ~reset_pend & slot_full[rd_ptr] & sym_cred;

    assign sym_valid = send_rst | send_bit;

    always_comb begin
        if (send_rst) begin
            sym.kind = SYM_RESET;
        end else if (cur.grb[bit_idx]) begin
            sym.kind = SYM_ONE;
        end else begin
            sym.kind = SYM_ZERO;
        end
    end

    always_ff @(posedge clk_in) begin
        if (pix_valid) begin
            slot_q[wr_ptr] <= pix_beat;
        end
    end

    always_ff @(posedge clk_in or negedge rst_n_in) begin
        if (!rst_n_in) begin
            slot_full  <= '0;
            wr_ptr     <= 1'b0;
            rd_ptr     <= 1'b0;
            bit_idx    <= 5'(GRB_W - 1);
            sym_cred   <= 1'b1;
            reset_pend <= 1'b0;
            pix_credit <= 1'b0;
        end else begin
            pix_credit <= 1'b0;
            sym_cred   <= (sym_cred & ~sym_valid) | sym_credit;

            if (pix_valid) begin
                slot_full[wr_ptr] <= 1'b1;
                wr_ptr            <= ~wr_ptr;
            end

            if (send_rst) begin
                reset_pend <= 1'b0;
            end

            if (send_bit) begin
                if (bit_idx == '0) begin
                    slot_full[rd_ptr] <= 1'b0;
                    rd_ptr            <= ~rd_ptr;
                    bit_idx           <= 5'(GRB_W - 1);
                    pix_credit        <= 1'b1;
                    reset_pend        <= cur.last;
                end else begin
                    bit_idx <= bit_idx - 5'd1;
                end
            end
        end
    end

    // the reader's credit count must keep a slot free for every beat.
    assert property (@(posedge clk_in) disable iff (!rst_n_in)
        pix_valid |-> !(&slot_full));

endmodule

/* design/pulse_encoder.sv */
/*
 * Pulse encoder.
 * Turns bit and reset symbols into the one-wire line waveform.
 */

`timescale 1ns/1ns

module pulse_encoder
    import ws2812_pkg::*;
(
    input  logic       clk_in,
    input  logic       rst_n_in,
    input  logic       sym_valid,
    input  symbol_t    sym,
    output logic       sym_credit,
    input  reset_len_t reset_len,
    output logic       dout,
    output logic       busy
);

    encoder_state_e state;
    symbol_t        sym_q;
    logic           reg_full;
    reset_len_t     cnt;
    logic           cur_one;
    logic           sym_end;
    logic           take;

    // last cycle of the running symbol, or nothing running.
    assign sym_end = (state == ENC_IDLE)
                     || ((state == ENC_LOW || state == ENC_RESET) && cnt == '0);
    assign take    = sym_end & reg_full;

    assign dout = (state == ENC_HIGH);
    assign busy = (state != ENC_IDLE) || reg_full;

    always_ff @(posedge clk_in) begin
        if (sym_valid) begin
            sym_q <= sym;
        end
    end

    always_ff @(posedge clk_in or negedge rst_n_in) begin
        if (!rst_n_in) begin
            state      <= ENC_IDLE;
            reg_full   <= 1'b0;
            cnt        <= '0;
            cur_one    <= 1'b0;
            sym_credit <= 1'b0;
        end else begin
            sym_credit <= take;

            if (sym_valid) begin
                reg_full <= 1'b1;
            end else if (take) begin
                reg_full <= 1'b0;
            end

            case (state)
                ENC_HIGH: begin
                    if (cnt == '0) begin
                        state <= ENC_LOW;
                        cnt   <= cur_one ? reset_len_t'(BIT_CYCLES - T1H_CYCLES - 1)
                                         : reset_len_t'(BIT_CYCLES - T0H_CYCLES - 1);
                    end else begin
                        cnt <= cnt - 1'b1;
                    end
                end
                ENC_LOW, ENC_RESET: begin
                    if (cnt != '0) begin
                        cnt <= cnt - 1'b1;
                    end
                end
                default: begin
                end
            endcase

            // next symbol follows without a gap.
            if (take) begin
                if (sym_q.kind == SYM_RESET) begin
                    state <= ENC_RESET;
                    cnt   <= (reset_len == '0) ? '0 : reset_len - 1'b1;
                end else begin
                    state   <= ENC_HIGH;
                    cur_one <= (sym_q.kind == SYM_ONE);
                    cnt     <= (sym_q.kind == SYM_ONE) ? reset_len_t'(T1H_CYCLES - 1)
                                                       : reset_len_t'(T0H_CYCLES - 1);
                end
            end else if (sym_end) begin
                state <= ENC_IDLE;
            end
        end
    end

    // the serializer holds at most one symbol credit.
    assert property (@(posedge clk_in) disable iff (!rst_n_in)
        sym_valid |-> !reg_full);

endmodule

/* design/ws2812_top.sv */
/*
 * WS2812 strip driver top level.
 * Pixel memory, frame reader, bit serializer and pulse encoder.
 */

`timescale 1ns/1ns

module ws2812_top
    import ws2812_pkg::*;
(
    input  logic       clk_in,
    input  logic       rst_n_in,
    input  logic       wr_en,
    input  ram_addr_t  wr_addr,
    input  logic [7:0] wr_data,
    input  byte_en_t   wr_byte_en,
    input  logic       start,
    input  reset_len_t reset_len,
    output logic       busy,
    output logic       dout
);

    logic        rd_en;
    ram_addr_t   rd_addr;
    ram_word_t   rd_word;
    logic        pix_valid;
    pixel_beat_t pix_beat;
    logic        pix_credit;
    logic        sym_valid;
    symbol_t     sym;
    logic        sym_credit;
    logic        rd_busy;
    logic        enc_busy;

    assign busy = rd_busy | enc_busy;

    pixel_ram u_ram (
        .clk_in, .rst_n_in, .wr_en, .wr_addr, .wr_data, .wr_byte_en,
        .rd_en, .rd_addr, .rd_word
    );

    // start is ignored until the previous frame has fully left the line.
    frame_reader u_reader (
        .clk_in, .rst_n_in, .start(start & ~busy), .rd_en, .rd_addr, .rd_word,
        .pix_valid, .pix_beat, .pix_credit, .busy(rd_busy)
    );

    bit_serializer u_serializer (
        .clk_in, .rst_n_in, .pix_valid, .pix_beat, .pix_credit,
        .sym_valid, .sym, .sym_credit
    );

    pulse_encoder u_encoder (
        .clk_in, .rst_n_in, .sym_valid, .sym, .sym_credit,
        .reset_len, .dout, .busy(enc_busy)
    );

endmodule

/* sim/tb_ws2812.sv */
/*
 * Testbench for the WS2812 strip driver.
 * Loads the pixel memory, starts frames, decodes the line waveform
 * and compares pixels and timing with the test data file.
 */

`timescale 1ns/1ns

module tb_ws2812
    import ws2812_pkg::*;
();

    localparam int MAX_FRAME_CYCLES = 100000;
    localparam int MID_HIGH         = (T0H_CYCLES + T1H_CYCLES) / 2;

    logic        clk_in = 1'b0;
    logic        rst_n_in;
    logic        wr_en;
    ram_addr_t   wr_addr;
    logic [7:0]  wr_data;
    byte_en_t    wr_byte_en;
    logic        start;
    reset_len_t  reset_len;
    logic        busy;
    logic        dout;

    logic [15:0] lfsr = 16'd63970;
    grb_t        exp_q[$];

    ws2812_top u_dut (
        .clk_in, .rst_n_in, .wr_en, .wr_addr, .wr_data, .wr_byte_en,
        .start, .reset_len, .busy, .dout
    );

    always #2 clk_in = ~clk_in;

    // **************************************************
    // checks.
    // **************************************************
    task automatic report_fail();
        $display("Something failed");
        $fatal(1);
    endtask

    task automatic check_pixel(string name, grb_t exp, grb_t act);
        if (act !== exp) begin
            $display("ERR %0t %s expected %h got %h", $time, name, exp, act);
            report_fail();
        end
    endtask

    task automatic check_reset_len(string name, reset_len_t exp, reset_len_t act);
        if (act !== exp) begin
            $display("ERR %0t %s expected %0d got %0d", $time, name, exp, act);
            report_fail();
        end
    endtask

    task automatic check_width(string name, reset_len_t exp, reset_len_t act);
        if (act !== exp) begin
            $display("ERR %0t %s expected %0d got %0d", $time, name, exp, act);
            report_fail();
        end
    endtask

    task automatic check_count(string name, ram_addr_t exp, ram_addr_t act);
        if (act !== exp) begin
            $display("ERR %0t %s expected %0d got %0d", $time, name, exp, act);
            report_fail();
        end
    endtask

    task automatic check_flag(string name, logic exp, logic act);
        if (act !== exp) begin
            $display("ERR %0t %s expected %b got %b", $time, name, exp, act);
            report_fail();
        end
    endtask

    task automatic expect_fields(int got, int want);
        if (got != want) begin
            $display("test data line has %0d fields where %0d were expected", got, want);
            report_fail();
        end
    endtask

    // **************************************************
    // stimulus.
    // **************************************************
    function automatic logic [15:0] lfsr_next(logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic idle_gap();
        int n;
        n = 0;
        for (int i = 0; i < 3; i++) begin
            lfsr = lfsr_next(lfsr);
            n = (n << 1) | int'(lfsr[0]);
        end
        repeat (n) @(negedge clk_in);
    endtask

    task automatic write_lanes(ram_addr_t addr, byte_en_t lanes, logic [7:0] data);
        @(negedge clk_in);
        wr_en      = 1'b1;
        wr_addr    = addr;
        wr_byte_en = lanes;
        wr_data    = data;
        @(negedge clk_in);
        wr_en      = 1'b0;
    endtask

    // starts a frame and decodes the line until busy falls.
    task automatic run_frame(reset_len_t rlen, ram_addr_t n_exp);
        reset_len_t high_len;
        reset_len_t low_len;
        reset_len_t since_rise;
        reset_len_t last_high;
        logic       prev_dout;
        logic       have_rise;
        grb_t       pix;
        int         n_bits;
        int         n_pix;
        int         cycles;
        high_len   = '0;
        low_len    = '0;
        since_rise = '0;
        last_high  = '0;
        prev_dout  = 1'b0;
        have_rise  = 1'b0;
        pix        = '0;
        n_bits     = 0;
        n_pix      = 0;
        cycles     = 0;
        @(negedge clk_in);
        reset_len = rlen;
        start     = 1'b1;
        @(negedge clk_in);
        start     = 1'b0;
        check_flag("busy", 1'b1, busy);
        while (busy) begin
            // a second start in the middle of the frame must be ignored.
            if (cycles == 10) begin
                start = 1'b1;
            end else begin
                start = 1'b0;
            end
            if (dout && !prev_dout) begin
                if (have_rise) begin
                    check_width("dout bit period", reset_len_t'(BIT_CYCLES), since_rise);
                end
                have_rise  = 1'b1;
                since_rise = '0;
                high_len   = '0;
            end
            if (!dout && prev_dout) begin
                last_high = high_len;
                pix       = {pix[GRB_W-2:0], high_len >= reset_len_t'(MID_HIGH)};
                check_width("dout high time", pix[0] ? reset_len_t'(T1H_CYCLES)
                                                     : reset_len_t'(T0H_CYCLES), high_len);
                low_len = '0;
                n_bits++;
                if (n_bits == GRB_W) begin
                    if (n_pix < exp_q.size()) begin
                        check_pixel("dout pixel", exp_q[n_pix], pix);
                    end
                    n_pix++;
                    n_bits = 0;
                end
            end
            if (dout) begin
                high_len++;
            end else begin
                low_len++;
            end
            since_rise++;
            prev_dout = dout;
            cycles++;
            if (cycles > MAX_FRAME_CYCLES) begin
                $display("timeout while waiting for busy to fall at the end of a frame");
                report_fail();
            end
            @(negedge clk_in);
        end
        start = 1'b0;
        if (n_bits != 0) begin
            $display("frame ended in the middle of a pixel after %0d bits", n_bits);
            report_fail();
        end
        check_count("pixel count", n_exp, ram_addr_t'(n_pix));
        check_reset_len("reset low time", rlen,
                        low_len - reset_len_t'(BIT_CYCLES) + last_high);
    endtask

    // **************************************************
    // test sequence from the data file.
    // **************************************************
    initial begin
        int            fd;
        int            code;
        logic [7:0]    op;
        logic [31:0]   a;
        logic [31:0]   b;
        logic [31:0]   c;
        logic [1023:0] skip_line;
        wr_en      = 1'b0;
        wr_addr    = '0;
        wr_data    = '0;
        wr_byte_en = '0;
        start      = 1'b0;
        reset_len  = '0;
        rst_n_in   = 1'b0;
        repeat (8) @(negedge clk_in);
        rst_n_in = 1'b1;
        check_flag("busy", 1'b0, busy);

        fd = $fopen("sim/ws2812_tests.txt", "r");
        if (fd == 0) begin
            $display("cannot open the test data file sim/ws2812_tests.txt");
            report_fail();
        end
        while ($fscanf(fd, " %c", op) == 1) begin
            case (op)
                "#": begin
                    code = $fgets(skip_line, fd);
                end
                "W": begin
                    code = $fscanf(fd, " %h %h %h", a, b, c);
                    expect_fields(code, 3);
                    idle_gap();
                    write_lanes(ram_addr_t'(a), byte_en_t'(b), c[7:0]);
                end
                "S": begin
                    code = $fscanf(fd, " %h %h", a, b);
                    expect_fields(code, 2);
                    exp_q.delete();
                    for (int i = 0; i < int'(b); i++) begin
                        code = $fscanf(fd, " %c %h", op, c);
                        expect_fields(code, 2);
                        exp_q.push_back(grb_t'(c));
                    end
                    idle_gap();
                    run_frame(reset_len_t'(a), ram_addr_t'(b));
                end
                default: begin
                    $display("unknown command %c in the test data file", op);
                    report_fail();
                end
            endcase
        end
        $fclose(fd);
        $display("Everything OK");
        $finish;
    end

endmodule

/* sim/ws2812_tests.txt */
# W addr lanes data : write the data byte into the enabled lanes of an entry (hex)
# S reset_len count : start a frame, then count P lines with the expected GRB (hex)
# single pixel, entry 00 carries the last flag
W 00 8 80
W 00 4 A5
W 00 2 3C
W 00 1 F0
S 0032 1
P A53CF0
# chain 00 -> 17 -> 05 -> 2A
W 00 8 17
W 17 8 05
W 17 7 5A
W 05 8 2A
W 05 4 FF
W 05 3 00
W 2A 8 80
W 2A 7 0F
S 0078 4
P A53CF0
P 5A5A5A
P FF0000
P 0F0F0F
# red lane of entry 17 only, and entry 05 now ends the chain
W 17 2 C3
W 05 8 80
S 012C 3
P A53CF0
P 5AC35A
P FF0000

/* sim.f */
design/ws2812_pkg.sv
design/pixel_ram.sv
design/frame_reader.sv
design/bit_serializer.sv
design/pulse_encoder.sv
design/ws2812_top.sv
sim/tb_ws2812.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the WS2812 driver testbench with Verilator.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f sim.f --top-module tb_ws2812 \
    --Mdir obj_dir -o tb_ws2812

./obj_dir/tb_ws2812
